// File: src.f
design/uart_cfg_pkg.sv
design/uart_data_pkg.sv
design/sync_fifo.sv
design/uart_rx.sv
design/uart_tx.sv
design/uart_rx_tx.sv
design/uart_fifo_top.sv
bench/uart_chk.sv
bench/uart_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP       = uart_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/uart_tb.sv
`timescale 1ns/1ns

module uart_tb;

    typedef logic [7:0] byte_q_t [$];
    typedef int int_q_t [$];

    localparam int fifo_depth_log2 = 4;
    localparam int fifo_depth      = 1 << fifo_depth_log2;
    // frames over all tests, 100 clocks of 20 ns each, plus a fifth.
    localparam int n_frames   = 55;
    localparam int timeout_ns = n_frames * 100 * 20 * 12 / 10;

    logic                        clk = 1'b0;
    logic                        resetn;
    logic                        rx;
    logic                        tx;
    uart_data_pkg::uart_byte_t   host_wdata;
    logic                        host_wen;
    logic                        host_full;
    logic                        host_ren;
    uart_data_pkg::uart_byte_t   host_rdata;
    logic                        host_empty;
    uart_data_pkg::uart_status_t status;
    logic                        rx_start;
    logic                        loopback;
    logic                        drv_line;
    integer                      seed;
    byte_q_t                     exp_q;
    byte_q_t                     dec_q;
    logic                        rd_pend = 1'b0;
    int                          rd_idx = 0;
    int                          chk_errs = 0;
    int                          cmp_errs = 0;
    int                          dec_errs = 0;
    int                          n_rx_done;
    int                          n_tx_done;
    int                          n_rx_err;
    int                          n_frame_err;
    int                          n_rx_start;

    always #10 clk = ~clk;

    assign rx = loopback ? tx : drv_line;

    uart_fifo_top #(
        .clk_frequency  (50_000_000),
        .baud_rate      (5_000_000),
        .fifo_depth_log2(fifo_depth_log2)
    ) UUT (
        .clk       (clk),
        .resetn    (resetn),
        .rx        (rx),
        .tx        (tx),
        .host_wdata(host_wdata),
        .host_wen  (host_wen),
        .host_full (host_full),
        .host_ren  (host_ren),
        .host_rdata(host_rdata),
        .host_empty(host_empty),
        .status    (status),
        .rx_start  (rx_start)
    );

    // **************************************************
    // reference model and checkers.
    // **************************************************

    // receive FIFO fill level; bytes past the depth are lost.
    function automatic void expected_rx(input byte_q_t sent, input int depth,
                                        input int_q_t read_at, output byte_q_t kept,
                                        output int lost);
        int fill;
        fill = 0;
        lost = 0;
        kept.delete();
        foreach (sent[i])
        begin
            foreach (read_at[j])
                if (read_at[j] == i && fill > 0)
                    fill--;
            if (fill < depth)
            begin
                kept.push_back(sent[i]);
                fill++;
            end
            else
                lost++;
        end
    endfunction

    // data shows up the cycle after an accepted read.
    always @(posedge clk)
    begin
        if (rd_pend)
        begin
            if (rd_idx >= exp_q.size())
            begin
                cmp_errs <= cmp_errs + 1;
                $display("ERR %0t: read returned %h with nothing expected", $time, host_rdata);
            end
            else if (host_rdata !== exp_q[rd_idx])
            begin
                cmp_errs <= cmp_errs + 1;
                $display("ERR %0t: read %h, expected %h", $time, host_rdata, exp_q[rd_idx]);
            end
            rd_idx <= rd_idx + 1;
        end
        rd_pend <= host_ren && !host_empty;
    end

    always @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            n_rx_done   <= 0;
            n_tx_done   <= 0;
            n_rx_err    <= 0;
            n_frame_err <= 0;
            n_rx_start  <= 0;
        end
        else
        begin
            if (status.rx_done)
                n_rx_done <= n_rx_done + 1;
            if (status.tx_done)
                n_tx_done <= n_tx_done + 1;
            if (status.rx_err)
                n_rx_err <= n_rx_err + 1;
            if (status.frame_err)
                n_frame_err <= n_frame_err + 1;
            if (rx_start)
                n_rx_start <= n_rx_start + 1;
        end
    end

    // mid-bit decoder on the transmit line.
    initial
    begin : line_decoder
        logic [7:0] shift;
        forever
        begin
            @(negedge tx);
            repeat (5) @(posedge clk);
            if (tx !== 1'b0)
            begin
                dec_errs++;
                $display("ERR %0t: start bit not low at mid-bit", $time);
            end
            for (int i = 0; i < 8; i++)
            begin
                repeat (10) @(posedge clk);
                shift = {tx, shift[7:1]};
            end
            repeat (10) @(posedge clk);
            if (tx !== 1'b1)
            begin
                dec_errs++;
                $display("ERR %0t: stop bit not high at mid-bit", $time);
            end
            dec_q.push_back(shift);
        end
    end

    initial
    begin
        #timeout_ns;
        $display("timeout: the tests did not finish in %0d ns", timeout_ns);
        $display("Simulation failed");
        $finish;
    end

    // **************************************************
    // stimulus tasks.
    // **************************************************

    task automatic write_when_room(input logic [7:0] b);
        @(posedge clk);
        while (host_full)
            @(posedge clk);
        host_wdata <= b;
        host_wen   <= 1'b1;
        @(posedge clk);
        host_wen <= 1'b0;
    endtask

    task automatic read_bytes(input int n);
        host_ren <= 1'b1;
        repeat (n) @(posedge clk);
        host_ren <= 1'b0;
        repeat (3) @(posedge clk);
    endtask

    // 8N1 frame on the driver line, then one idle bit.
    task automatic send_frame(input logic [7:0] b, input logic stop_bit);
        logic [9:0] bits;
        bits = {stop_bit, b, 1'b0};
        repeat (10)
        begin
            drv_line <= bits[0];
            bits = bits >> 1;
            repeat (10) @(posedge clk);
        end
        drv_line <= 1'b1;
        repeat (10) @(posedge clk);
    endtask

    task automatic read_and_check(input byte_q_t sent, input int err_base);
        byte_q_t kept;
        int_q_t  no_reads;
        int      lost;
        expected_rx(sent, fifo_depth, no_reads, kept, lost);
        foreach (kept[i])
            exp_q.push_back(kept[i]);
        read_bytes(kept.size());
        if (rd_idx != exp_q.size())
        begin
            chk_errs++;
            $display("not every expected byte was read back from the receive FIFO");
        end
        if (n_rx_err - err_base != lost)
        begin
            chk_errs++;
            $display("ERR %0t: %0d overflow pulses, expected %0d", $time,
                     n_rx_err - err_base, lost);
        end
        if (host_empty !== 1'b1)
        begin
            chk_errs++;
            $display("receive FIFO still holds data after the reads");
        end
    endtask

    task automatic check_line(input byte_q_t want, input int first, input int tx_base);
        while (n_tx_done < tx_base + want.size())
            @(posedge clk);
        repeat (4) @(posedge clk);
        if (n_tx_done - tx_base != want.size())
        begin
            chk_errs++;
            $display("ERR %0t: %0d tx_done pulses, expected %0d", $time,
                     n_tx_done - tx_base, want.size());
        end
        if (dec_q.size() - first != want.size())
        begin
            chk_errs++;
            $display("decoder saw %0d frames instead of %0d", dec_q.size() - first, want.size());
        end
        else
            foreach (want[i])
                if (dec_q[first + i] !== want[i])
                begin
                    chk_errs++;
                    $display("ERR %0t: line byte %0d is %h, expected %h", $time, i,
                             dec_q[first + i], want[i]);
                end
    endtask

    // **************************************************
    // test sequence.
    // **************************************************

    initial
    begin : main_seq
        byte_q_t     sent;
        logic [31:0] rnd;
        int          base_rx;
        int          base_err;
        int          base_fe;
        int          base_st;
        int          base_tx;
        int          dec_base;
        int          dropped;
        resetn     = 1'b0;
        host_wdata = '0;
        host_wen   = 1'b0;
        host_ren   = 1'b0;
        loopback   = 1'b0;
        drv_line   = 1'b1;
        seed       = 32'hce73;
        repeat (8) @(posedge clk);
        resetn <= 1'b1;
        repeat (2) @(posedge clk);

        // reset state.
        if (tx !== 1'b1 || status.tx_idle !== 1'b1 || status.rx_idle !== 1'b1
            || host_empty !== 1'b1 || host_full !== 1'b0 || rx_start !== 1'b0
            || status.rx_err !== 1'b0 || status.frame_err !== 1'b0
            || status.tx_done !== 1'b0 || status.rx_done !== 1'b0)
        begin
            chk_errs++;
            $display("ERR %0t: outputs after reset are %b %b %b %b %b", $time,
                     tx, status, host_empty, host_full, rx_start);
        end

        // loopback order.
        loopback <= 1'b1;
        base_rx  = n_rx_done;
        base_err = n_rx_err;
        for (int i = 0; i < 12; i++)
        begin
            rnd = $random(seed);
            sent.push_back(rnd[7:0]);
            write_when_room(rnd[7:0]);
        end
        while (n_rx_done < base_rx + 12)
            @(posedge clk);
        repeat (4) @(posedge clk);
        if (n_rx_done - base_rx != 12)
        begin
            chk_errs++;
            $display("ERR %0t: %0d rx_done pulses, expected 12", $time, n_rx_done - base_rx);
        end
        read_and_check(sent, base_err);

        // transmit framing.
        loopback <= 1'b0;
        sent.delete();
        dec_base = dec_q.size();
        base_tx  = n_tx_done;
        for (int i = 0; i < 5; i++)
        begin
            rnd = $random(seed);
            sent.push_back(rnd[7:0]);
            write_when_room(rnd[7:0]);
        end
        check_line(sent, dec_base, base_tx);

        // receive overflow, 18 bytes into 16 entries.
        loopback <= 1'b1;
        sent.delete();
        base_rx  = n_rx_done;
        base_err = n_rx_err;
        for (int i = 0; i < 18; i++)
        begin
            rnd = $random(seed);
            sent.push_back(rnd[7:0]);
            write_when_room(rnd[7:0]);
        end
        while (n_rx_done < base_rx + 18)
            @(posedge clk);
        repeat (4) @(posedge clk);
        read_and_check(sent, base_err);

        // framing error, then a good frame.
        loopback <= 1'b0;
        sent.delete();
        base_fe  = n_frame_err;
        base_st  = n_rx_start;
        base_rx  = n_rx_done;
        base_err = n_rx_err;
        @(posedge clk);
        rnd = $random(seed);
        send_frame(rnd[7:0], 1'b0);
        rnd = $random(seed);
        sent.push_back(rnd[7:0]);
        send_frame(rnd[7:0], 1'b1);
        repeat (4) @(posedge clk);
        if (n_frame_err - base_fe != 1 || n_rx_start - base_st != 2 || n_rx_done - base_rx != 1)
        begin
            chk_errs++;
            $display("ERR %0t: frame_err %0d, rx_start %0d, rx_done %0d, expected 1, 2, 1",
                     $time, n_frame_err - base_fe, n_rx_start - base_st, n_rx_done - base_rx);
        end
        read_and_check(sent, base_err);

        // back-to-back writes; the transmitter drains one, so 18 reach full.
        sent.delete();
        dec_base = dec_q.size();
        base_tx  = n_tx_done;
        dropped  = 0;
        for (int i = 0; i < 18; i++)
        begin
            rnd = $random(seed);
            host_wdata <= rnd[7:0];
            host_wen   <= 1'b1;
            @(posedge clk);
            if (host_full)
                dropped++;
            else
                sent.push_back(rnd[7:0]);
        end
        host_wen <= 1'b0;
        if (dropped == 0)
        begin
            chk_errs++;
            $display("host_full never blocked a write to the transmit FIFO");
        end
        check_line(sent, dec_base, base_tx);

        repeat (4) @(posedge clk);
        $display("error counts: checks %0d, read data %0d, line decode %0d",
                 chk_errs, cmp_errs, dec_errs);
        if (chk_errs + cmp_errs + dec_errs == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: bench/uart_chk.sv
`timescale 1ns/1ns

module uart_chk (
    input logic clk,
    input logic resetn,
    input logic fifo_ren,
    input logic fifo_empty,
    input logic tx,
    input logic tx_idle,
    input logic rx_wen,
    input logic rx_err
);

    // a fetch needs data and puts the start bit out two cycles later.
    ren_needs_data: assert property (@(posedge clk) disable iff (!resetn)
        fifo_ren |-> !fifo_empty ##2 !tx)
        else $error("transmit FIFO read while empty or not followed by a start bit");

    // idle line must be high.
    line_high_when_idle: assert property (@(posedge clk) disable iff (!resetn)
        tx_idle |-> tx)
        else $error("tx low while transmitter idle");

    // overflow follows a write and lasts a single cycle per lost byte.
    rx_err_after_write: assert property (@(posedge clk) disable iff (!resetn)
        rx_err |-> $past(rx_wen) ##1 !rx_err)
        else $error("rx_err without a receive FIFO write or held for more than one cycle");

endmodule

bind uart_rx_tx uart_chk chk_u (
    .clk       (clk),
    .resetn    (resetn),
    .fifo_ren  (tx_fifo_ren),
    .fifo_empty(tx_fifo_empty),
    .tx        (tx),
    .tx_idle   (tx_idle),
    .rx_wen    (rx_fifo_wen),
    .rx_err    (rx_err_q)
);

// File: design/uart_fifo_top.sv
`timescale 1ns/1ns

module uart_fifo_top #(
    parameter int clk_frequency   = uart_cfg_pkg::default_clk_frequency,
    parameter int baud_rate       = uart_cfg_pkg::default_baud_rate,
    parameter int fifo_depth_log2 = uart_data_pkg::default_fifo_depth_log2
)(
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        rx,
    output logic                        tx,
    input  uart_data_pkg::uart_byte_t   host_wdata,
    input  logic                        host_wen,
    output logic                        host_full,
    input  logic                        host_ren,
    output uart_data_pkg::uart_byte_t   host_rdata,
    output logic                        host_empty,
    output uart_data_pkg::uart_status_t status,
    output logic                        rx_start
);

    uart_data_pkg::uart_byte_t tx_fifo_dout;
    logic                      tx_fifo_empty;
    logic                      tx_fifo_ren;
    uart_data_pkg::uart_byte_t rx_fifo_din;
    logic                      rx_fifo_wen;
    logic                      rx_fifo_full;

    // **************************************************
    // host side buffers.
    // **************************************************

    sync_fifo #(
        .depth_log2(fifo_depth_log2)
    ) tx_fifo_u (
        .clk   (clk),
        .resetn(resetn),
        .din   (host_wdata),
        .wen   (host_wen),
        .ren   (tx_fifo_ren),
        .dout  (tx_fifo_dout),
        .full  (host_full),
        .empty (tx_fifo_empty)
    );

    sync_fifo #(
        .depth_log2(fifo_depth_log2)
    ) rx_fifo_u (
        .clk   (clk),
        .resetn(resetn),
        .din   (rx_fifo_din),
        .wen   (rx_fifo_wen),
        .ren   (host_ren),
        .dout  (host_rdata),
        .full  (rx_fifo_full),
        .empty (host_empty)
    );

    // **************************************************
    // serial engine.
    // **************************************************

    uart_rx_tx #(
        .clk_frequency(clk_frequency),
        .baud_rate    (baud_rate)
    ) uart_u (
        .clk          (clk),
        .resetn       (resetn),
        .rx           (rx),
        .tx           (tx),
        .rx_fifo_din  (rx_fifo_din),
        .rx_fifo_wen  (rx_fifo_wen),
        .rx_fifo_full (rx_fifo_full),
        .tx_fifo_dout (tx_fifo_dout),
        .tx_fifo_empty(tx_fifo_empty),
        .tx_fifo_ren  (tx_fifo_ren),
        .status       (status),
        .rx_start     (rx_start)
    );

endmodule

// File: design/uart_rx_tx.sv
`timescale 1ns/1ns

module uart_rx_tx #(
    parameter int clk_frequency = uart_cfg_pkg::default_clk_frequency,
    parameter int baud_rate     = uart_cfg_pkg::default_baud_rate
)(
    input  logic                        clk,
    input  logic                        resetn,
    input  logic                        rx,
    output logic                        tx,
    output uart_data_pkg::uart_byte_t   rx_fifo_din,
    output logic                        rx_fifo_wen,
    input  logic                        rx_fifo_full,
    input  uart_data_pkg::uart_byte_t   tx_fifo_dout,
    input  logic                        tx_fifo_empty,
    output logic                        tx_fifo_ren,
    output uart_data_pkg::uart_status_t status,
    output logic                        rx_start
);

    // rounded to the nearest whole clock.
    localparam int clks_per_bit = (clk_frequency + baud_rate / 2) / baud_rate;

    logic rx_err_q;
    logic frame_err;
    logic tx_idle;
    logic rx_idle;
    logic tx_done;

    // a write into a full receive FIFO loses the byte.
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            rx_err_q <= 1'b0;
        else
            rx_err_q <= rx_fifo_wen & rx_fifo_full;
    end

    uart_rx #(
        .clks_per_bit(clks_per_bit)
    ) uart_rx_u (
        .clk          (clk),
        .resetn       (resetn),
        .rx           (rx),
        .rx_byte      (rx_fifo_din),
        .rx_byte_valid(rx_fifo_wen),
        .frame_err    (frame_err),
        .rx_idle      (rx_idle),
        .rx_start     (rx_start)
    );

    uart_tx #(
        .clks_per_bit(clks_per_bit)
    ) uart_tx_u (
        .clk       (clk),
        .resetn    (resetn),
        .fifo_dout (tx_fifo_dout),
        .fifo_empty(tx_fifo_empty),
        .fifo_ren  (tx_fifo_ren),
        .tx        (tx),
        .tx_idle   (tx_idle),
        .tx_done   (tx_done)
    );

    assign status.rx_err    = rx_err_q;
    assign status.frame_err = frame_err;
    assign status.tx_idle   = tx_idle;
    assign status.rx_idle   = rx_idle;
    assign status.tx_done   = tx_done;
    assign status.rx_done   = rx_fifo_wen;

endmodule

// File: design/uart_tx.sv
`timescale 1ns/1ns

module uart_tx #(
    parameter int clks_per_bit = 434
)(
    input  logic                      clk,
    input  logic                      resetn,
    input  uart_data_pkg::uart_byte_t fifo_dout,
    input  logic                      fifo_empty,
    output logic                      fifo_ren,
    output logic                      tx,
    output logic                      tx_idle,
    output logic                      tx_done
);

    localparam uart_cfg_pkg::baud_cnt_t last_cnt =
        uart_cfg_pkg::baud_cnt_t'(clks_per_bit - 1);

    uart_data_pkg::tx_state_t  state;
    uart_cfg_pkg::baud_cnt_t   cnt;
    uart_data_pkg::bit_idx_t   bit_idx;
    uart_data_pkg::uart_byte_t shreg;
    logic                      tx_q;
    logic                      bit_end;

    assign bit_end = (cnt == last_cnt);

    // counter only runs while a bit is on the line.
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            cnt <= '0;
        else if (state == uart_data_pkg::tx_st_idle || state == uart_data_pkg::tx_st_fetch)
            cnt <= '0;
        else if (bit_end)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state   <= uart_data_pkg::tx_st_idle;
            bit_idx <= '0;
            tx_q    <= 1'b1;
        end
        else
        begin
            case (state)
                uart_data_pkg::tx_st_idle:
                    if (!fifo_empty)
                        state <= uart_data_pkg::tx_st_fetch;
                // FIFO data is valid here, start bit goes out next.
                uart_data_pkg::tx_st_fetch:
                begin
                    state <= uart_data_pkg::tx_st_start;
                    tx_q  <= 1'b0;
                end
                uart_data_pkg::tx_st_start:
                    if (bit_end)
                    begin
                        state   <= uart_data_pkg::tx_st_data;
                        bit_idx <= '0;
                        tx_q    <= shreg[0];
                    end
                uart_data_pkg::tx_st_data:
                    if (bit_end)
                    begin
                        if (bit_idx == 3'd7)
                        begin
                            state <= uart_data_pkg::tx_st_stop;
                            tx_q  <= 1'b1;
                        end
                        else
                        begin
                            bit_idx <= bit_idx + 3'd1;
                            tx_q    <= shreg[1];
                        end
                    end
                uart_data_pkg::tx_st_stop:
                    if (bit_end)
                        state <= uart_data_pkg::tx_st_idle;
                default:
                    state <= uart_data_pkg::tx_st_idle;
            endcase
        end
    end

    // shifts right as each data bit completes.
    always_ff @(posedge clk)
    begin
        if (state == uart_data_pkg::tx_st_fetch)
            shreg <= fifo_dout;
        else if (state == uart_data_pkg::tx_st_data && bit_end)
            shreg <= {1'b0, shreg[7:1]};
    end

    assign fifo_ren = (state == uart_data_pkg::tx_st_idle) && !fifo_empty;
    assign tx       = tx_q;
    assign tx_idle  = (state == uart_data_pkg::tx_st_idle);
    assign tx_done  = (state == uart_data_pkg::tx_st_stop) && bit_end;

endmodule

// File: design/uart_rx.sv
`timescale 1ns/1ns

module uart_rx #(
    parameter int clks_per_bit = 434
)(
    input  logic                      clk,
    input  logic                      resetn,
    input  logic                      rx,
    output uart_data_pkg::uart_byte_t rx_byte,
    output logic                      rx_byte_valid,
    output logic                      frame_err,
    output logic                      rx_idle,
    output logic                      rx_start
);

    localparam uart_cfg_pkg::baud_cnt_t last_cnt =
        uart_cfg_pkg::baud_cnt_t'(clks_per_bit - 1);
    localparam uart_cfg_pkg::baud_cnt_t half_cnt =
        uart_cfg_pkg::baud_cnt_t'(clks_per_bit / 2 - 1);

    logic                      rx_meta;
    logic                      rx_sync;
    logic                      rx_prev;
    logic                      rx_fall;
    logic                      sample;
    uart_data_pkg::rx_state_t  state;
    uart_cfg_pkg::baud_cnt_t   cnt;
    uart_data_pkg::bit_idx_t   bit_idx;
    uart_data_pkg::uart_byte_t shreg;

    // **************************************************
    // input synchronizer and edge detect.
    // **************************************************

    // line idles high, so the flops come out of reset high.
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign rx_fall = rx_prev & ~rx_sync;

    // **************************************************
    // bit timing and frame FSM.
    // **************************************************

    // first sample at half a bit, then once per bit period.
    assign sample = (state == uart_data_pkg::rx_st_start) ? (cnt == half_cnt)
                                                          : (cnt == last_cnt);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            cnt <= '0;
        else if (state == uart_data_pkg::rx_st_idle || sample)
            cnt <= '0;
        else
            cnt <= cnt + 1'b1;
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state   <= uart_data_pkg::rx_st_idle;
            bit_idx <= '0;
        end
        else
        begin
            case (state)
                uart_data_pkg::rx_st_idle:
                    if (rx_fall)
                        state <= uart_data_pkg::rx_st_start;
                uart_data_pkg::rx_st_start:
                    if (sample)
                    begin
                        // glitch, not a real start bit.
                        if (rx_sync)
                            state <= uart_data_pkg::rx_st_idle;
                        else
                        begin
                            state   <= uart_data_pkg::rx_st_data;
                            bit_idx <= '0;
                        end
                    end
                uart_data_pkg::rx_st_data:
                    if (sample)
                    begin
                        if (bit_idx == 3'd7)
                            state <= uart_data_pkg::rx_st_stop;
                        else
                            bit_idx <= bit_idx + 3'd1;
                    end
                uart_data_pkg::rx_st_stop:
                    if (sample)
                        state <= uart_data_pkg::rx_st_idle;
                default:
                    state <= uart_data_pkg::rx_st_idle;
            endcase
        end
    end

    // lsb arrives first.
    always_ff @(posedge clk)
    begin
        if (state == uart_data_pkg::rx_st_data && sample)
            shreg <= {rx_sync, shreg[7:1]};
    end

    assign rx_byte       = shreg;
    assign rx_byte_valid = (state == uart_data_pkg::rx_st_stop) && sample && rx_sync;
    assign frame_err     = (state == uart_data_pkg::rx_st_stop) && sample && !rx_sync;
    assign rx_idle       = (state == uart_data_pkg::rx_st_idle);
    assign rx_start      = (state == uart_data_pkg::rx_st_idle) && rx_fall;

endmodule

// File: design/sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
    parameter int depth_log2 = 4
)(
    input  logic                      clk,
    input  logic                      resetn,
    input  uart_data_pkg::uart_byte_t din,
    input  logic                      wen,
    input  logic                      ren,
    output uart_data_pkg::uart_byte_t dout,
    output logic                      full,
    output logic                      empty
);

    localparam int depth = 1 << depth_log2;

    uart_data_pkg::uart_byte_t mem [depth];
    logic [depth_log2:0]       wptr;
    logic [depth_log2:0]       rptr;
    logic                      do_write;
    logic                      do_read;

    assign do_write = wen && !full;
    assign do_read  = ren && !empty;

    // extra msb tells a full buffer from an empty one.
    assign empty = (wptr == rptr);
    assign full  = (wptr[depth_log2] != rptr[depth_log2])
                && (wptr[depth_log2-1:0] == rptr[depth_log2-1:0]);

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            wptr <= '0;
            rptr <= '0;
        end
        else
        begin
            if (do_write)
                wptr <= wptr + 1'b1;
            if (do_read)
                rptr <= rptr + 1'b1;
        end
    end

    // storage and read data register.
    always_ff @(posedge clk)
    begin
        if (do_write)
            mem[wptr[depth_log2-1:0]] <= din;
        if (do_read)
            dout <= mem[rptr[depth_log2-1:0]];
    end

endmodule

// File: design/uart_data_pkg.sv
package uart_data_pkg;

    // one data byte on the line or in a FIFO.
    typedef logic [7:0] uart_byte_t;

    // index of the data bit inside a frame.
    typedef logic [2:0] bit_idx_t;

    // default FIFO depth as log2, so the pointers are one bit wider.
    localparam int default_fifo_depth_log2 = 4;

    // status toward the host.
    typedef struct packed {
        logic rx_err;      // receive FIFO overflow, one-cycle pulse.
        logic frame_err;   // low stop bit, one-cycle pulse.
        logic tx_idle;
        logic rx_idle;
        logic tx_done;     // last cycle of the stop bit.
        logic rx_done;     // byte accepted.
    } uart_status_t;

    typedef enum logic [1:0] {
        rx_st_idle,
        rx_st_start,
        rx_st_data,
        rx_st_stop
    } rx_state_t;

    typedef enum logic [2:0] {
        tx_st_idle,
        tx_st_fetch,
        tx_st_start,
        tx_st_data,
        tx_st_stop
    } tx_state_t;

endpackage

// File: design/uart_cfg_pkg.sv
package uart_cfg_pkg;

    // **************************************************
    // clock and baud defaults.
    // **************************************************

    // system clock in Hz.
    localparam int default_clk_frequency = 50_000_000;

    // serial line rate in bits per second.
    localparam int default_baud_rate = 115_200;

    // **************************************************
    // bit timing.
    // **************************************************

    // counts clocks inside one bit period.
    // 16 bits covers clock/baud ratios up to 65535.
    typedef logic [15:0] baud_cnt_t;

endpackage
